// File: list.f
source/cpu_pkg.sv
source/pipe_buses.sv
source/alu.sv
source/register_file.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/retire_unit.sv
source/pipeline_cpu.sv
sim/wb_checker.sv
sim/tb_cpu.sv

// File: Makefile
# Verilator lint, simulation and clean targets for the pipelined core

TOP = tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/tb_cpu.sv
// Testbench top: clock, reset, program table, instruction memory model, expected writes
`timescale 1ns/1ns

module tb_cpu import cpu_pkg::*; ();

    localparam word_t RESET_PC = '0;
    localparam int    TIMEOUT  = 400;       // Cycles to wait for all writes

    logic      clk = 1'b0;
    logic      rst;
    word_t     i_addr;
    word_t     i_data;
    logic      wb_wr;
    reg_addr_t wb_reg;
    word_t     wb_data;
    logic      done;
    int        value_errs;
    int        other_errs;

    word_t        prog [$];                 // Program table, word index from RESET_PC
    logic [25:0]  pos_imm, neg_imm;
    word_t        pos_val, neg_val;         // Sign-extended immediates, held in r1 and r2
    word_t        v3, v4, v5, v6, v7, v8;
    int           cycles;
    int           timeout_errs = 0;

    pipeline_cpu #(.RESET_PC(RESET_PC)) UUT (
        .clk(clk), .rst(rst), .i_addr(i_addr), .i_data(i_data),
        .wb_wr(wb_wr), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    wb_checker #(.RESET_PC(RESET_PC)) wb_check (
        .clk(clk), .rst(rst), .i_addr(i_addr), .wb_wr(wb_wr), .wb_reg(wb_reg),
        .wb_data(wb_data), .done(done), .value_errs(value_errs), .other_errs(other_errs)
    );

    always #5 clk = ~clk;                   // 10 ns period

    // Instruction memory, refreshed whenever the fetch address moves at an edge
    always @(i_addr)
        i_data <= fetch_word(i_addr);

    function automatic word_t fetch_word(input word_t addr);
        int idx;
        idx = int'((addr - RESET_PC) >> 2);
        if ($isunknown(addr) || idx >= prog.size())
            return NOP_WORD;                // Past the table
        return prog[idx];
    endfunction

    function automatic word_t encode_r(input alu_op_t op, input reg_addr_t rs,
                                       input reg_addr_t rt, input reg_addr_t rd,
                                       input shamt_t sh, input logic [2:0] zcn,
                                       input logic wr, input logic frc);
        return {2'b00, 1'b0, wr, frc, op[3], rs, rt, rd, sh, op[2:0], zcn};
    endfunction

    function automatic word_t encode_imm(input logic [25:0] v);
        return {2'b01, 1'b0, 1'b1, 2'b01, v};
    endfunction

    function automatic word_t encode_branch(input logic pol, input cond_t cond,
                                            input logic [25:0] off);
        return {2'b10, pol, 1'b0, cond, off};
    endfunction

    task automatic put(input word_t w);
        prog.push_back(w);
    endtask

    task automatic move_op(input alu_op_t op, input reg_addr_t rs, input reg_addr_t rt,
                           input reg_addr_t rd, input shamt_t sh, input logic [2:0] zcn,
                           input string name, input word_t v);
        put(encode_r(op, rs, rt, rd, sh, zcn, 1'b1, 1'b0));
        wb_check.add_expect(name, rd, v);
    endtask

    // Branch, fall-through marker (r1), target marker (r2)
    task automatic branch_case(input string name, input logic pol, input cond_t cond,
                               input logic taken, input reg_addr_t dest);
        put(encode_branch(pol, cond, 26'd1));    // Target is two words on
        put(encode_r(ALU_PASS, 5'd1, 5'd0, dest, 5'd0, 3'b000, 1'b1, 1'b0));
        put(encode_r(ALU_PASS, 5'd2, 5'd0, dest, 5'd0, 3'b000, 1'b1, 1'b0));
        if (!taken)
            wb_check.add_expect({name, "_fall"}, dest, pos_val);
        wb_check.add_expect({name, "_target"}, dest, neg_val);
    endtask

    task automatic force_flags(input logic [2:0] zcn);
        put(encode_r(ALU_PASS, 5'd0, 5'd0, 5'd0, 5'd0, zcn, 1'b0, 1'b1));
    endtask

    initial
    begin
        rst    = 1'b1;
        i_data = NOP_WORD;
        // First call seeds the generator
        pos_imm = {1'b0, 25'($urandom(32'h345dca23))} | 26'h10;   // Bit 25 clear, never zero
        neg_imm = {1'b1, 25'($urandom)};
        pos_val = {{6{pos_imm[25]}}, pos_imm};
        neg_val = {{6{neg_imm[25]}}, neg_imm};

        // Immediates into r0, copied to r1 and r2
        put(encode_imm(pos_imm));
        wb_check.add_expect("imm_pos", 5'd0, pos_val);
        move_op(ALU_PASS, 5'd0, 5'd0, 5'd1, 5'd0, 3'b000, "mov_pos", pos_val);
        put(encode_imm(neg_imm));
        wb_check.add_expect("imm_neg", 5'd0, neg_val);
        move_op(ALU_PASS, 5'd0, 5'd0, 5'd2, 5'd0, 3'b000, "mov_neg", neg_val);

        // Dependent chain through EX/MEM, MEM/WB and write-through
        v3 = pos_val & neg_val;
        v4 = v3 | pos_val;
        v5 = v4 ^ v3;
        v6 = v5 + neg_val;
        v7 = v6 - pos_val;
        v8 = {v7[28:0], 3'b000};
        move_op(ALU_AND, 5'd1, 5'd2, 5'd3, 5'd0, 3'b000, "and", v3);
        move_op(ALU_OR,  5'd3, 5'd1, 5'd4, 5'd0, 3'b000, "or", v4);
        move_op(ALU_XOR, 5'd4, 5'd3, 5'd5, 5'd0, 3'b000, "xor", v5);
        move_op(ALU_ADD, 5'd5, 5'd2, 5'd6, 5'd0, 3'b000, "add", v6);
        move_op(ALU_SUB, 5'd6, 5'd1, 5'd7, 5'd0, 3'b000, "sub", v7);
        move_op(ALU_SLL, 5'd7, 5'd0, 5'd8, 5'd3, 3'b000, "sll", v8);
        move_op(ALU_SRL, 5'd8, 5'd0, 5'd9, 5'd5, 3'b000, "srl", {5'd0, v8[31:5]});
        // Ones shifted in since neg_val is negative
        move_op(ALU_SRA, 5'd2, 5'd0, 5'd10, 5'd4, 3'b000, "sra", {4'hF, neg_val[31:4]});

        // Flags from subtract: equal gives Z=1 C=1 N=0
        move_op(ALU_SUB, 5'd1, 5'd1, 5'd11, 5'd0, 3'b111, "sub_eq", 32'd0);
        branch_case("bz_set", 1'b1, COND_Z, 1'b1, 5'd12);
        branch_case("bz_clear", 1'b0, COND_Z, 1'b0, 5'd13);
        // Small positive minus negative borrows, Z=0 C=0 N=0
        move_op(ALU_SUB, 5'd1, 5'd2, 5'd14, 5'd0, 3'b111, "sub_borrow", pos_val - neg_val);
        branch_case("bc_clear", 1'b0, COND_C, 1'b1, 5'd15);
        branch_case("bc_set", 1'b1, COND_C, 1'b0, 5'd16);
        // Negative minus positive, Z=0 C=1 N=1
        move_op(ALU_SUB, 5'd2, 5'd1, 5'd17, 5'd0, 3'b111, "sub_neg", neg_val - pos_val);
        branch_case("bn_set", 1'b1, COND_N, 1'b1, 5'd18);
        branch_case("bn_clear", 1'b0, COND_N, 1'b0, 5'd19);

        // Forced flags
        force_flags(3'b010);
        branch_case("force_c", 1'b1, COND_C, 1'b1, 5'd20);
        branch_case("force_z", 1'b1, COND_Z, 1'b0, 5'd21);
        force_flags(3'b101);
        branch_case("force_n", 1'b1, COND_N, 1'b1, 5'd22);
        branch_case("force_nz", 1'b0, COND_Z, 1'b0, 5'd23);

        // Jump over one marker, then branch-always
        put({2'b11, 30'(((RESET_PC >> 2) + prog.size() + 2))});
        put(encode_r(ALU_PASS, 5'd1, 5'd0, 5'd24, 5'd0, 3'b000, 1'b1, 1'b0));
        put(encode_r(ALU_PASS, 5'd2, 5'd0, 5'd24, 5'd0, 3'b000, 1'b1, 1'b0));
        wb_check.add_expect("jump_target", 5'd24, neg_val);
        branch_case("b_always", 1'b0, COND_ALWAYS, 1'b1, 5'd25);

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        cycles = 0;
        while (!done && cycles < TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!done)
        begin
            $display("Error: timed out after %0d cycles waiting for write-backs", cycles);
            timeout_errs++;
        end

        // Drain so stray writes behind the last one are caught
        for (int i = 0; i < 10; i++)
            @(posedge clk);
        wb_check.report_missing();

        $display("Errors: %0d wrong values, %0d other, %0d timeouts",
                 value_errs, other_errs, timeout_errs);
        if (value_errs + other_errs + timeout_errs == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: sim/wb_checker.sv
// Write-back checker: expected write queue, reset checks, error counters
`timescale 1ns/1ns

module wb_checker import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      rst,
    input  word_t     i_addr,
    input  logic      wb_wr,
    input  reg_addr_t wb_reg,
    input  word_t     wb_data,
    output logic      done,                 // Every expected write seen
    output int        value_errs,
    output int        other_errs
);

    string     exp_name [$];                // Expected writes in retire order
    reg_addr_t exp_reg  [$];
    word_t     exp_val  [$];
    int        seen = 0;
    logic      rst_q = 1'b1;                // Covers the first cycle after reset

    initial
    begin
        done       = 1'b0;
        value_errs = 0;
        other_errs = 0;
    end

    task automatic add_expect(input string name, input reg_addr_t r, input word_t v);
        exp_name.push_back(name);
        exp_reg.push_back(r);
        exp_val.push_back(v);
    endtask

    task automatic report_missing();
        if (seen < exp_reg.size())
        begin
            $display("Error: %0d expected write-backs never appeared, next was %s",
                     exp_reg.size() - seen, exp_name[seen]);
            other_errs += exp_reg.size() - seen;
        end
    endtask

    always @(posedge clk)
        rst_q <= rst;

    // Sample mid-cycle where the port is stable
    always @(negedge clk)
    begin
        if (rst || rst_q)
        begin
            if (wb_wr !== 1'b0)
            begin
                $display("Error: write-back port active during or just after reset");
                other_errs++;
            end
            if (i_addr !== RESET_PC)
            begin
                $display("Error: fetch address %h is not the reset PC %h", i_addr, RESET_PC);
                other_errs++;
            end
        end
        else if (wb_wr === 1'b1)
        begin
            if (seen >= exp_reg.size())
            begin
                $display("Error: unexpected write of %h to r%0d", wb_data, wb_reg);
                other_errs++;
            end
            else
            begin
                if (wb_reg !== exp_reg[seen] || wb_data !== exp_val[seen])
                begin
                    $display("Fail %s: expected r%0d = %h, actual r%0d = %h", exp_name[seen],
                             exp_reg[seen], exp_val[seen], wb_reg, wb_data);
                    value_errs++;
                end
                seen++;
            end
        end
        done <= (exp_reg.size() > 0) && (seen >= exp_reg.size());
    end

endmodule

// File: source/pipeline_cpu.sv
// Five-stage core top level: bus interfaces and stage instances
`timescale 1ns/1ns

module pipeline_cpu import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      rst,
    output word_t     i_addr,
    input  word_t     i_data,
    output logic      wb_wr,
    output reg_addr_t wb_reg,
    output word_t     wb_data
);

    fetch_bus fb ();                    // Fetch and decode
    issue_bus ib ();                    // Decode into execute

    flags_t    next_flags;              // Flag forwarding into decode
    flags_t    flag_wr;
    logic      mem_wr;                  // EX/MEM into retire
    reg_addr_t mem_reg;
    word_t     mem_data;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst(rst), .i_addr(i_addr), .i_data(i_data), .fb(fb.fetch_side)
    );

    decode_unit u_decode (
        .clk(clk), .rst(rst), .fb(fb.decode_side), .ib(ib.decode_side),
        .ex_flags(next_flags), .ex_flag_wr(flag_wr),
        .wb_wr(wb_wr), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    execute_unit u_execute (
        .clk(clk), .rst(rst), .ib(ib.exec_side), .next_flags(next_flags), .flag_wr(flag_wr),
        .mem_wr(mem_wr), .mem_reg(mem_reg), .mem_data(mem_data),
        .wb_wr(wb_wr), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    retire_unit u_retire (
        .clk(clk), .rst(rst), .mem_wr(mem_wr), .mem_reg(mem_reg), .mem_data(mem_data),
        .wb_wr(wb_wr), .wb_reg(wb_reg), .wb_data(wb_data)
    );

endmodule

// File: source/retire_unit.sv
// Retire unit: MEM/WB register driving the write-back port
`timescale 1ns/1ns

module retire_unit import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      mem_wr,
    input  reg_addr_t mem_reg,
    input  word_t     mem_data,
    output logic      wb_wr,            // To top level, register file and execute
    output reg_addr_t wb_reg,
    output word_t     wb_data
);

    always_ff @(posedge clk)
    begin
        if (rst)
            wb_wr <= 1'b0;              // No retirement out of reset
        else
            wb_wr <= mem_wr;
        wb_reg  <= mem_reg;
        wb_data <= mem_data;
    end

    // Register file commits at the following edge
    a_wb_known: assert property (@(posedge clk) disable iff (rst)
        wb_wr |-> !$isunknown({wb_reg, wb_data}));

endmodule

// File: source/execute_unit.sv
// Execute unit: operand forwarding, ALU, flag registers and forcing, EX/MEM register
`timescale 1ns/1ns

module execute_unit import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    issue_bus.exec_side     ib,
    output flags_t          next_flags,             // Flag state after this edge, to decode
    output flags_t          flag_wr,                // Flags being written this cycle
    output logic            mem_wr,                 // EX/MEM
    output reg_addr_t       mem_reg,
    output word_t           mem_data,
    input  logic            wb_wr,                  // MEM/WB, last forwarding source
    input  reg_addr_t       wb_reg,
    input  word_t           wb_data
);

    word_t  fwd_a, fwd_b;
    word_t  alu_a;
    word_t  alu_y;
    logic   alu_zero;
    logic   alu_carry;
    flags_t new_flags;                              // Forced or ALU-derived values
    flags_t flags_q;                                // Z, C, N registers

    // Newest producer wins, EX/MEM before MEM/WB before the issued read
    function automatic word_t fwd(input reg_addr_t r, input word_t issued);
        if (mem_wr && (mem_reg == r))
            return mem_data;
        else if (wb_wr && (wb_reg == r))
            return wb_data;
        else
            return issued;
    endfunction

    assign fwd_a = fwd(ib.rs, ib.rs_val);
    assign fwd_b = fwd(ib.rt, ib.rt_val);
    assign alu_a = ib.use_imm ? ib.imm : fwd_a;     // Immediate load passes imm through

    alu u_alu (
        .a     (alu_a),
        .b     (fwd_b),
        .op    (ib.alu_op),
        .shamt (ib.imm[10:6]),
        .y     (alu_y),
        .zero  (alu_zero),
        .carry (alu_carry)
    );

    // Forcing takes the enable bits as values and writes all three
    assign new_flags = ib.force_flags ? ib.flag_wr : flags_t'({alu_zero, alu_carry, alu_y[31]});
    assign flag_wr   = ib.flag_wr | {3{ib.force_flags}};

    // Per-flag merge, unwritten flags keep their state
    assign next_flags = (flag_wr & new_flags) | (~flag_wr & flags_q);

    always_ff @(posedge clk)
    begin
        if (rst)
            flags_q <= '0;
        else
            flags_q <= next_flags;
    end

    // EX/MEM register
    always_ff @(posedge clk)
    begin
        if (rst)
            mem_wr <= 1'b0;
        else
            mem_wr <= ib.wr_reg;
        mem_reg  <= ib.dest;
        mem_data <= alu_y;                          // Memory stage passes this on untouched
    end

    // Decode never pairs an immediate load with forced flags
    a_no_force_imm: assert property (@(posedge clk) disable iff (rst)
        ib.use_imm |-> !ib.force_flags);

endmodule

// File: source/decode_unit.sv
// Decode unit: field split, format decode, branch and jump resolution, ID/EX register
`timescale 1ns/1ns

module decode_unit import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    fetch_bus.decode_side   fb,
    issue_bus.decode_side   ib,
    input  flags_t          ex_flags,               // Next flag state from execute
    input  flags_t          ex_flag_wr,             // Flags execute is writing this cycle
    input  logic            wb_wr,
    input  reg_addr_t       wb_reg,
    input  word_t           wb_data
);

    word_t     ir;
    fmt_t      fmt;
    cond_t     cond;
    reg_addr_t rs, rt, rd;
    funct_t    funct;
    word_t     imm_se;                              // Sign-extended bits 25:0
    word_t     rs_val, rt_val;
    word_t     br_target;
    word_t     jmp_target;
    logic      flag_sel;
    logic      take;

    assign ir    = fb.ir;
    assign fmt   = fmt_t'(ir[31:30]);
    assign cond  = cond_t'(ir[27:26]);
    assign rs    = ir[25:21];
    assign rt    = ir[20:16];
    assign rd    = ir[15:11];
    assign funct = ir[5:0];
    assign imm_se = {{(XLEN-IMM_W){ir[IMM_W-1]}}, ir[IMM_W-1:0]};

    register_file rf (
        .clk     (clk),
        .rst     (rst),
        .rs      (rs),
        .rt      (rt),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .wr      (wb_wr),
        .wr_reg  (wb_reg),
        .wr_data (wb_data)                          // Same-cycle write shows on the reads
    );

    // Flag for the branch condition, execute result already merged per flag
    always_comb
    begin
        case (cond)
            COND_Z:  flag_sel = ex_flags.z;
            COND_C:  flag_sel = ex_flags.c;
            COND_N:  flag_sel = ex_flags.n;
            default: flag_sel = 1'b1;
        endcase
    end

    assign take       = (cond == COND_ALWAYS) || (flag_sel == ir[29]);  // Bit 29 is polarity
    assign br_target  = fb.link_pc + {imm_se[XLEN-3:0], 2'b00};
    assign jmp_target = {ir[29:0], 2'b00};

    // Every branch redirects, untaken ones refetch the squashed fall-through
    assign fb.redirect    = (fmt == FMT_BRANCH) || (fmt == FMT_JUMP);
    assign fb.redirect_pc = (fmt == FMT_JUMP) ? jmp_target :
                            take              ? br_target  : fb.link_pc;

    // ID/EX payload
    always_ff @(posedge clk)
    begin
        ib.rs_val <= rs_val;
        ib.rt_val <= rt_val;
        ib.rs     <= rs;
        ib.rt     <= rt;
        ib.imm    <= imm_se;
        ib.dest   <= (fmt == FMT_IMM) ? 5'd0 : rd;  // Immediate load always targets r0
        ib.alu_op <= (fmt == FMT_IMM) ? ALU_PASS : alu_op_t'({ir[26], funct[5:3]});
    end

    // ID/EX controls, branches and jumps issue as bubbles
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ib.use_imm     <= 1'b0;
            ib.wr_reg      <= 1'b0;
            ib.flag_wr     <= '0;
            ib.force_flags <= 1'b0;
        end
        else
        begin
            ib.use_imm     <= (fmt == FMT_IMM);
            ib.wr_reg      <= ((fmt == FMT_R) || (fmt == FMT_IMM)) && ir[28];
            ib.flag_wr     <= (fmt == FMT_R) ? flags_t'(funct[2:0]) : '0;   // Z C N enables
            ib.force_flags <= (fmt == FMT_R) && ir[27];
        end
    end

    // Bit 29 is reserved in R-format
    a_r_bit29: assert property (@(posedge clk) disable iff (rst)
        (fmt == FMT_R) |-> !ir[29]);

endmodule

// File: source/fetch_unit.sv
// Fetch unit: program counter, next-PC select, IF/ID register with squash
`timescale 1ns/1ns

module fetch_unit import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0                  // Word-aligned start address
) (
    input  logic            clk,
    input  logic            rst,
    output word_t           i_addr,                 // To instruction memory
    input  word_t           i_data,                 // Combinational read data
    fetch_bus.fetch_side    fb
);

    word_t pc;
    word_t pc_plus4;
    word_t pc_next;

    assign pc_plus4 = pc + 32'd4;
    assign pc_next  = fb.redirect ? fb.redirect_pc : pc_plus4;    // Decode overrides sequential fetch
    assign i_addr   = pc;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc    <= RESET_PC;
            fb.ir <= NOP_WORD;                      // Decode sees nothing valid out of reset
        end
        else
        begin
            pc    <= pc_next;
            fb.ir <= fb.redirect ? NOP_WORD : i_data;   // Squash the slot behind a branch or jump
        end
        fb.link_pc <= pc_plus4;                     // Return point of the fetched word
    end

    // The squashed NOP in decode can never itself redirect
    a_single_redirect: assert property (@(posedge clk) disable iff (rst)
        fb.redirect |=> !fb.redirect);

endmodule

// File: source/register_file.sv
// 32 by 32 register file, asynchronous reads with write-through
`timescale 1ns/1ns

module register_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    output word_t     rs_val,
    output word_t     rt_val,
    input  logic      wr,
    input  reg_addr_t wr_reg,
    input  word_t     wr_data
);

    word_t regs [32];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;              // Whole file starts at zero
        end
        else if (wr)
        begin
            regs[wr_reg] <= wr_data;        // r0 is an ordinary register
        end
    end

    // Bypass the write landing at this edge
    assign rs_val = (wr && (wr_reg == rs)) ? wr_data : regs[rs];
    assign rt_val = (wr && (wr_reg == rt)) ? wr_data : regs[rt];

endmodule

// File: source/alu.sv
// ALU: logic, add, subtract and shifts with zero and carry outputs
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    input  shamt_t  shamt,
    output word_t   y,
    output logic    zero,
    output logic    carry
);

    logic [XLEN:0] add_full;                        // Carry in the top bit
    logic [XLEN:0] sub_full;                        // Top bit set when no borrow

    assign add_full = {1'b0, a} + {1'b0, b};
    assign sub_full = {1'b0, a} + {1'b0, ~b} + 33'd1;  // Two's complement a minus b

    always_comb
    begin
        carry = 1'b0;
        case (op)
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            ALU_ADD:
            begin
                y     = add_full[XLEN-1:0];
                carry = add_full[XLEN];
            end
            ALU_SUB:
            begin
                y     = sub_full[XLEN-1:0];
                carry = sub_full[XLEN];
            end
            ALU_SLL: y = a << shamt;                // Shifts act on a
            ALU_SRL: y = a >> shamt;
            ALU_SRA: y = word_t'($signed(a) >>> shamt);
            default: y = a;                         // ALU_PASS and unused codes
        endcase
    end

    assign zero = (y == '0);

endmodule

// File: source/pipe_buses.sv
// fetch_bus and issue_bus interfaces with their modports
`timescale 1ns/1ns

// IF/ID contents toward decode, redirect back toward fetch
interface fetch_bus import cpu_pkg::*; ();

    word_t ir;                  // Instruction in decode
    word_t link_pc;             // Address of the instruction after ir
    logic  redirect;            // Branch or jump resolved in decode
    word_t redirect_pc;         // PC to load at the next edge

    modport fetch_side (
        output ir,
        output link_pc,
        input  redirect,
        input  redirect_pc
    );

    modport decode_side (
        input  ir,
        input  link_pc,
        output redirect,
        output redirect_pc
    );

endinterface

// ID/EX register contents, all driven by decode
interface issue_bus import cpu_pkg::*; ();

    word_t     rs_val;          // Register file read of rs
    word_t     rt_val;          // Register file read of rt
    reg_addr_t rs;              // Kept for operand forwarding
    reg_addr_t rt;
    reg_addr_t dest;            // Write-back register
    word_t     imm;             // Sign-extended 26-bit field, shamt sits in 10:6
    alu_op_t   alu_op;
    logic      use_imm;         // Immediate replaces operand a
    logic      wr_reg;          // Result goes to dest
    flags_t    flag_wr;         // Per-flag update enables, forced values when force_flags
    logic      force_flags;

    modport decode_side (
        output rs_val, rt_val, rs, rt, dest, imm,
        output alu_op, use_imm, wr_reg, flag_wr, force_flags
    );

    modport exec_side (
        input  rs_val, rt_val, rs, rt, dest, imm,
        input  alu_op, use_imm, wr_reg, flag_wr, force_flags
    );

endinterface

// File: source/cpu_pkg.sv
// Shared widths, instruction field types, format, condition and ALU enums, flag struct
package cpu_pkg;

    localparam int XLEN  = 32;                  // Data and address width
    localparam int IMM_W = 26;                  // Immediate and branch offset field width

    typedef logic [XLEN-1:0] word_t;            // Data or address word
    typedef logic [4:0]      reg_addr_t;        // Register number
    typedef logic [4:0]      shamt_t;           // Shift amount field, bits 10:6
    typedef logic [5:0]      funct_t;           // R-format funct field, bits 5:0

    // Instruction format, bits 31:30
    typedef enum logic [1:0] {
        FMT_R      = 2'b00,                     // Register ALU operation
        FMT_IMM    = 2'b01,                     // Sign-extended load into register 0
        FMT_BRANCH = 2'b10,                     // PC-relative branch on a flag
        FMT_JUMP   = 2'b11                      // Absolute jump
    } fmt_t;

    // Branch condition, bits 27:26
    typedef enum logic [1:0] {
        COND_Z      = 2'b00,
        COND_C      = 2'b01,
        COND_N      = 2'b10,
        COND_ALWAYS = 2'b11
    } cond_t;

    // ALU operation: shift select bit, then funct bits 5:3
    // Codes outside this list behave as ALU_PASS
    typedef enum logic [3:0] {
        ALU_AND  = 4'b0000,
        ALU_OR   = 4'b0001,
        ALU_XOR  = 4'b0010,
        ALU_PASS = 4'b0011,                     // Operand a straight through
        ALU_ADD  = 4'b0100,
        ALU_SUB  = 4'b0101,                     // Plain a minus b
        ALU_SLL  = 4'b1000,
        ALU_SRL  = 4'b1010,
        ALU_SRA  = 4'b1011
    } alu_op_t;

    // Condition flags, also reused as per-flag write enables
    typedef struct packed {
        logic z;                                // Zero
        logic c;                                // Carry, or no borrow on subtract
        logic n;                                // Negative, result bit 31
    } flags_t;

    // All-zero word decodes as R-format with no register or flag write
    localparam word_t NOP_WORD = '0;

endpackage
